// ==== hw/apb_pkg.sv ====
/* APB bus widths and types shared by every link in the design.
   One transfer is in flight per link and there is no PSLVERR or PPROT. */
package apb_pkg;

    ////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 16;

    // external masters sharing the bus
    localparam int NUM_MASTERS = 2;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // names one master, wide enough for NUM_MASTERS
    typedef logic [$clog2(NUM_MASTERS)-1:0] master_id_t;

    ////////////////////////////////////////////////////////////
    // arbiter FSM
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        idle   = 2'd0,
        setup  = 2'd1,
        access = 2'd2
    } arb_state_e;

endpackage

// ==== hw/soc_map_pkg.sv ====
/* Address map and sizes of the slaves. Regions are 4 KB, picked by addr[15:12];
   regions other than GPIO and RAM are unmapped and read as zero. */
package soc_map_pkg;

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////
    localparam int REGION_MSB = 15;
    localparam int REGION_LSB = 12;

    localparam logic [REGION_MSB-REGION_LSB:0] REGION_GPIO = 4'h0;
    localparam logic [REGION_MSB-REGION_LSB:0] REGION_BRAM = 4'h1;

    typedef enum logic [1:0] {
        sel_gpio = 2'd0,
        sel_bram = 2'd1,
        sel_none = 2'd2
    } slave_sel_e;

    ////////////////////////////////////////////////////////////
    // slave sizes
    ////////////////////////////////////////////////////////////
    // must not exceed the bus data width
    localparam int GPIO_PINS = 16;

    localparam int BRAM_DEPTH = 64;
    localparam int BRAM_ADDR_BITS = $clog2(BRAM_DEPTH);

    // soft reset stretch after the external reset
    localparam int RESET_HOLD_CYCLES = 8;
    localparam int HOLD_COUNT_BITS = $clog2(RESET_HOLD_CYCLES + 1);

endpackage

// ==== hw/apb_if.sv ====
/* One APB link without clock or reset. The master holds the request
   signals stable from psel until pready is seen at a rising edge. */
`timescale 1ns/1ps

interface apb_if;
    import apb_pkg::*;

    // request side, driven by the master
    addr_t paddr;
    logic  pwrite;
    logic  psel;
    logic  penable;
    data_t pwdata;

    // response side, driven by the slave
    data_t prdata;
    logic  pready;

    modport master (
        output paddr, pwrite, psel, penable, pwdata,
        input  prdata, pready
    );

    modport slave (
        input  paddr, pwrite, psel, penable, pwdata,
        output prdata, pready
    );

endinterface

// ==== hw/reset_hold.sv ====
/* Stretches the external reset by RESET_HOLD_CYCLES clocks; the stretched
   soft reset also covers the whole time that reset is high. */
`timescale 1ns/1ps

module reset_hold (
    input  logic clk,
    input  logic reset,
    output logic soft_reset
);
    import soc_map_pkg::*;

    logic [HOLD_COUNT_BITS-1:0] count;

    // reload while reset is high, then run down to zero
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= HOLD_COUNT_BITS'(RESET_HOLD_CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign soft_reset = reset | (count != '0);

endmodule

// ==== hw/apb_arbiter.sv ====
/* Round-robin arbiter for two APB masters onto one shared link. The waiting
   master sees pready low and must hold its request until it is served. */
`timescale 1ns/1ps

module apb_arbiter (
    input logic clk,
    input logic reset,
    apb_if.slave  m0,
    apb_if.slave  m1,
    apb_if.master shared
);
    import apb_pkg::*;

    arb_state_e state;
    master_id_t grant;
    master_id_t last_served;
    master_id_t pick;
    logic       any_req;
    logic       in_access;

    ////////////////////////////////////////////////////////////
    // request selection
    ////////////////////////////////////////////////////////////
    assign any_req = m0.psel | m1.psel;

    // on a tie the master not served last wins
    always_comb begin
        if (m0.psel && m1.psel) begin
            pick = ~last_served;
        end else if (m1.psel) begin
            pick = 1'b1;
        end else begin
            pick = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // transfer FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= idle;
            grant       <= 1'b0;
            last_served <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (any_req) begin
                        state <= setup;
                        grant <= pick;
                    end
                end
                setup: begin
                    state <= access;
                end
                access: begin
                    // transfer ends on the edge where the slave is ready
                    if (shared.pready) begin
                        state       <= idle;
                        last_served <= grant;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // shared bus request, muxed from the granted master
    ////////////////////////////////////////////////////////////
    assign in_access = (state == access);

    assign shared.psel    = (state != idle);
    assign shared.penable = in_access;

    always_comb begin
        if (grant == 1'b1) begin
            shared.paddr  = m1.paddr;
            shared.pwrite = m1.pwrite;
            shared.pwdata = m1.pwdata;
        end else begin
            shared.paddr  = m0.paddr;
            shared.pwrite = m0.pwrite;
            shared.pwdata = m0.pwdata;
        end
    end

    // response goes back to the granted master only
    assign m0.pready = in_access && (grant == 1'b0) && shared.pready;
    assign m1.pready = in_access && (grant == 1'b1) && shared.pready;

    assign m0.prdata = (grant == 1'b0) ? shared.prdata : '0;
    assign m1.prdata = (grant == 1'b1) ? shared.prdata : '0;

endmodule

// ==== hw/apb_decoder.sv ====
/* Splits the shared link by addr[15:12] into GPIO and RAM. Unmapped regions
   answer in the first access cycle with zero data and discard writes. */
`timescale 1ns/1ps

module apb_decoder (
    apb_if.slave  up,
    apb_if.master gpio_side,
    apb_if.master bram_side
);
    import soc_map_pkg::*;

    slave_sel_e sel;

    always_comb begin
        case (up.paddr[REGION_MSB:REGION_LSB])
            REGION_GPIO: sel = sel_gpio;
            REGION_BRAM: sel = sel_bram;
            default:     sel = sel_none;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // request fan-out, psel only to the selected slave
    ////////////////////////////////////////////////////////////
    assign gpio_side.paddr   = up.paddr;
    assign gpio_side.pwrite  = up.pwrite;
    assign gpio_side.penable = up.penable;
    assign gpio_side.pwdata  = up.pwdata;
    assign gpio_side.psel    = up.psel && (sel == sel_gpio);

    assign bram_side.paddr   = up.paddr;
    assign bram_side.pwrite  = up.pwrite;
    assign bram_side.penable = up.penable;
    assign bram_side.pwdata  = up.pwdata;
    assign bram_side.psel    = up.psel && (sel == sel_bram);

    ////////////////////////////////////////////////////////////
    // response merge
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (sel)
            sel_gpio: begin
                up.prdata = gpio_side.prdata;
                up.pready = gpio_side.pready;
            end
            sel_bram: begin
                up.prdata = bram_side.prdata;
                up.pready = bram_side.pready;
            end
            default: begin
                // nothing there, complete at once
                up.prdata = '0;
                up.pready = up.psel && up.penable;
            end
        endcase
    end

endmodule

// ==== hw/gpio_apb.sv ====
/* GPIO output register, no wait states. Every offset in the region maps to
   the same register; pins above bit GPIO_PINS-1 read as zero. */
`timescale 1ns/1ps

module gpio_apb (
    input  logic clk,
    input  logic reset,
    apb_if.slave bus,
    output logic [soc_map_pkg::GPIO_PINS-1:0] gpio
);
    import apb_pkg::*;
    import soc_map_pkg::*;

    logic [GPIO_PINS-1:0] gpio_q;
    logic                 access_cyc;

    assign access_cyc = bus.psel && bus.penable;

    // load on the access edge of a write
    always_ff @(posedge clk) begin
        if (reset) begin
            gpio_q <= '0;
        end else if (access_cyc && bus.pwrite) begin
            gpio_q <= bus.pwdata[GPIO_PINS-1:0];
        end
    end

    assign gpio = gpio_q;

    ////////////////////////////////////////////////////////////
    // bus response
    ////////////////////////////////////////////////////////////
    assign bus.pready = access_cyc;
    assign bus.prdata = data_t'(gpio_q);

endmodule

// ==== hw/bram_apb.sv ====
/* Word-addressed RAM slave with one wait state; only addr[5:0] is decoded,
   so the region aliases every 64 words. Contents start undefined. */
`timescale 1ns/1ps

module bram_apb (
    input logic clk,
    input logic reset,
    apb_if.slave bus
);
    import apb_pkg::*;
    import soc_map_pkg::*;

    data_t mem [BRAM_DEPTH];

    logic [BRAM_ADDR_BITS-1:0] idx;
    data_t                     rdata_q;
    logic                      wait_q;
    logic                      access_cyc;
    logic                      first_edge;

    assign idx        = bus.paddr[BRAM_ADDR_BITS-1:0];
    assign access_cyc = bus.psel && bus.penable;
    assign first_edge = access_cyc && !wait_q;

    ////////////////////////////////////////////////////////////
    // wait state, set on the first access edge
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            wait_q <= 1'b0;
        end else if (access_cyc) begin
            wait_q <= ~wait_q;
        end
    end

    ////////////////////////////////////////////////////////////
    // memory array
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (first_edge) begin
            if (bus.pwrite) begin
                mem[idx] <= bus.pwdata;
            end
            // old word, held until pready
            rdata_q <= mem[idx];
        end
    end

    assign bus.pready = access_cyc && wait_q;
    assign bus.prdata = rdata_q;

endmodule

// ==== hw/apb_soc.sv ====
/* Two external APB masters sharing a GPIO register and a 64-word RAM.
   Transfers issued while the soft reset is held stall until it ends. */
`timescale 1ns/1ps

module apb_soc (
    input  logic                              clk,
    input  logic                              reset,
    // master 0
    input  apb_pkg::addr_t                    m0_paddr,
    input  logic                              m0_pwrite,
    input  logic                              m0_psel,
    input  logic                              m0_penable,
    input  apb_pkg::data_t                    m0_pwdata,
    output apb_pkg::data_t                    m0_prdata,
    output logic                              m0_pready,
    // master 1
    input  apb_pkg::addr_t                    m1_paddr,
    input  logic                              m1_pwrite,
    input  logic                              m1_psel,
    input  logic                              m1_penable,
    input  apb_pkg::data_t                    m1_pwdata,
    output apb_pkg::data_t                    m1_prdata,
    output logic                              m1_pready,
    output logic [soc_map_pkg::GPIO_PINS-1:0] gpio
);
    logic soft_reset;

    apb_if m0_bus ();
    apb_if m1_bus ();
    apb_if shared_bus ();
    apb_if gpio_bus ();
    apb_if bram_bus ();

    ////////////////////////////////////////////////////////////
    // master ports onto their links
    ////////////////////////////////////////////////////////////
    assign m0_bus.paddr   = m0_paddr;
    assign m0_bus.pwrite  = m0_pwrite;
    assign m0_bus.psel    = m0_psel;
    assign m0_bus.penable = m0_penable;
    assign m0_bus.pwdata  = m0_pwdata;
    assign m0_prdata      = m0_bus.prdata;
    assign m0_pready      = m0_bus.pready;

    assign m1_bus.paddr   = m1_paddr;
    assign m1_bus.pwrite  = m1_pwrite;
    assign m1_bus.psel    = m1_psel;
    assign m1_bus.penable = m1_penable;
    assign m1_bus.pwdata  = m1_pwdata;
    assign m1_prdata      = m1_bus.prdata;
    assign m1_pready      = m1_bus.pready;

    ////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////
    reset_hold reset_hold_inst (
        .clk        (clk),
        .reset      (reset),
        .soft_reset (soft_reset)
    );

    apb_arbiter arbiter_inst (
        .clk    (clk),
        .reset  (soft_reset),
        .m0     (m0_bus.slave),
        .m1     (m1_bus.slave),
        .shared (shared_bus.master)
    );

    apb_decoder decoder_inst (
        .up        (shared_bus.slave),
        .gpio_side (gpio_bus.master),
        .bram_side (bram_bus.master)
    );

    gpio_apb gpio_inst (
        .clk   (clk),
        .reset (soft_reset),
        .bus   (gpio_bus.slave),
        .gpio  (gpio)
    );

    bram_apb bram_inst (
        .clk   (clk),
        .reset (soft_reset),
        .bus   (bram_bus.slave)
    );

endmodule

// ==== tests/tb_clock.sv ====
/* Free-running testbench clock with a 20 ns period, starting low. */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);
    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// ==== tests/apb_soc_asserts.sv ====
/* Concurrent checks bound into the arbiter. They are idle while the
   arbiter's own reset (the stretched soft reset) is high. */
`timescale 1ns/1ps

module apb_soc_asserts (
    input logic           clk,
    input logic           reset,
    input logic           shared_psel,
    input logic           shared_penable,
    input logic           shared_pready,
    input apb_pkg::addr_t shared_paddr,
    input logic           m0_psel,
    input logic           m0_pready,
    input logic           m1_psel,
    input logic           m1_pready
);

    // access phase only inside a selected transfer
    assert property (@(posedge clk) disable iff (reset) shared_penable |-> shared_psel)
        else $error("shared penable high without shared psel");

    // address held from setup until the slave answers
    assert property (@(posedge clk) disable iff (reset)
        (shared_psel && !(shared_penable && shared_pready)) |=> $stable(shared_paddr))
        else $error("shared address changed inside a transfer");

    assert property (@(posedge clk) disable iff (reset) !(m0_pready && m1_pready))
        else $error("both master preadys high together");

    assert property (@(posedge clk) disable iff (reset) m0_pready |-> m0_psel)
        else $error("master 0 pready without a request");

    assert property (@(posedge clk) disable iff (reset) m1_pready |-> m1_psel)
        else $error("master 1 pready without a request");

endmodule

bind apb_arbiter apb_soc_asserts asserts_inst (
    .clk            (clk),
    .reset          (reset),
    .shared_psel    (shared.psel),
    .shared_penable (shared.penable),
    .shared_pready  (shared.pready),
    .shared_paddr   (shared.paddr),
    .m0_psel        (m0.psel),
    .m0_pready      (m0.pready),
    .m1_psel        (m1.psel),
    .m1_pready      (m1.pready)
);

// ==== tests/apb_soc_tb.sv ====
/* Two random APB masters checked against a model of the RAM and GPIO register.
   Master 1 never writes GPIO and owns its own RAM half, so service order is free. */
`timescale 1ns/1ps

module apb_soc_tb;
    import apb_pkg::*;
    import soc_map_pkg::*;

    localparam logic [31:0] SEED           = 32'h110234ed;
    localparam int          TIMEOUT_CYCLES = 50;
    localparam int          NUM_TRANSFERS  = 200;

    logic                 clk;
    logic                 reset;
    addr_t                m0_paddr;
    logic                 m0_pwrite;
    logic                 m0_psel;
    logic                 m0_penable;
    data_t                m0_pwdata;
    data_t                m0_prdata;
    logic                 m0_pready;
    addr_t                m1_paddr;
    logic                 m1_pwrite;
    logic                 m1_psel;
    logic                 m1_penable;
    data_t                m1_pwdata;
    data_t                m1_prdata;
    logic                 m1_pready;
    logic [GPIO_PINS-1:0] gpio;

    // model and bookkeeping
    logic [31:0] lfsr_state [2];
    data_t       model_ram [BRAM_DEPTH];
    bit          model_valid [BRAM_DEPTH];
    data_t       model_gpio;
    time         done_time [2];
    int          last_done;

    tb_clock clock_inst (.clk(clk));

    apb_soc apb_soc_inst (.*);

    ////////////////////////////////////////////////////////////
    // random numbers and checks
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit taken, separate stream per master
    task automatic random_bits(input int m, input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[m][0]};
            lfsr_state[m] = lfsr_next(lfsr_state[m]);
        end
    endtask

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error at %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // master side of one APB transfer
    ////////////////////////////////////////////////////////////
    task automatic drive_master(input int m, input logic sel, input logic en,
                                input addr_t addr, input logic wr, input data_t wdata);
        if (m == 0) begin
            m0_psel    = sel;
            m0_penable = en;
            m0_paddr   = addr;
            m0_pwrite  = wr;
            m0_pwdata  = wdata;
        end else begin
            m1_psel    = sel;
            m1_penable = en;
            m1_paddr   = addr;
            m1_pwrite  = wr;
            m1_pwdata  = wdata;
        end
    endtask

    // starts 1 ns after an edge, returns 1 ns after the pready edge
    task automatic do_transfer(input int m, input addr_t addr, input logic wr,
                               input data_t wdata, output data_t rdata, output int cycles);
        logic  ready;
        data_t data;
        bit    done;
        int    n;
        drive_master(m, 1'b1, 1'b0, addr, wr, wdata);
        done = 1'b0;
        n    = 0;
        while (!done) begin
            // sample mid-cycle, well clear of the edges
            @(negedge clk);
            ready = (m == 0) ? m0_pready : m1_pready;
            data  = (m == 0) ? m0_prdata : m1_prdata;
            @(posedge clk);
            n++;
            #1;
            if (ready) begin
                done = 1'b1;
            end else if (n >= TIMEOUT_CYCLES) begin
                $display("master %0d got no pready within %0d cycles", m, n);
                abort_run();
            end else begin
                drive_master(m, 1'b1, 1'b1, addr, wr, wdata);
            end
        end
        drive_master(m, 1'b0, 1'b0, addr, wr, wdata);
        rdata        = data;
        cycles       = n;
        done_time[m] = $time;
        last_done    = m;
    endtask

    task automatic random_transfer(input int m);
        logic [31:0] r;
        int          kind;
        logic        wr;
        data_t       wdata;
        data_t       rdata;
        logic [11:0] offset;
        logic [5:0]  idx;
        addr_t       addr;
        int          n;
        random_bits(m, 2, r);
        kind = int'(r[1:0]);
        random_bits(m, 1, r);
        wr = r[0];
        random_bits(m, 16, r);
        wdata = r[15:0];
        random_bits(m, 12, r);
        offset = r[11:0];
        // master 0 owns words 0 to 31, master 1 words 32 to 63
        random_bits(m, 5, r);
        idx = {m[0], r[4:0]};
        if (kind < 2) begin
            addr = {4'h1, 6'h00, idx};
        end else if (m == 0 && kind == 2) begin
            addr = {4'h0, offset};
        end else if (m == 0) begin
            addr = {4'hf, offset};
        end else begin
            // regions 8 to 15, all unmapped
            addr = {1'b1, offset[11:9], offset};
        end
        do_transfer(m, addr, wr, wdata, rdata, n);
        if (addr[REGION_MSB:REGION_LSB] == REGION_BRAM) begin
            if (wr) begin
                model_ram[idx]   = wdata;
                model_valid[idx] = 1'b1;
            end else if (model_valid[idx]) begin
                check_equal(32'(rdata), 32'(model_ram[idx]), "ram read data");
            end
        end else if (addr[REGION_MSB:REGION_LSB] == REGION_GPIO) begin
            if (wr) begin
                model_gpio = wdata;
            end else begin
                check_equal(32'(rdata), 32'(model_gpio), "gpio read data");
            end
        end else if (!wr) begin
            check_equal(32'(rdata), 32'h0, "unmapped read data");
        end
        // pins only change on master 0 transfers
        if (m == 0) begin
            check_equal(32'(gpio), 32'(model_gpio), "gpio pins");
        end
        random_bits(m, 2, r);
        if (r[1:0] != 2'b00) begin
            repeat (r[1:0]) @(posedge clk);
            #1;
        end
    endtask

    // both masters raise psel in the same cycle
    task automatic contend_once();
        data_t rdata0;
        data_t rdata1;
        int    n0;
        int    n1;
        int    first;
        first = 1 - last_done;
        fork
            do_transfer(0, 16'h0004, 1'b0, 16'h0000, rdata0, n0);
            do_transfer(1, 16'h9000, 1'b0, 16'h0000, rdata1, n1);
        join
        check_equal(32'(rdata0), 32'(model_gpio), "gpio read under contention");
        check_equal(32'(rdata1), 32'h0, "unmapped read under contention");
        check_equal(32'(done_time[first] < done_time[1 - first]), 32'h1,
                    "master not served last wins the tie");
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int    n;
        data_t rdata;
        reset = 1'b1;
        drive_master(0, 1'b0, 1'b0, '0, 1'b0, '0);
        drive_master(1, 1'b0, 1'b0, '0, 1'b0, '0);
        lfsr_state[0] = SEED;
        lfsr_state[1] = SEED;
        // master 1 runs the same sequence 16 steps ahead
        repeat (16) lfsr_state[1] = lfsr_next(lfsr_state[1]);
        for (int i = 0; i < BRAM_DEPTH; i++) begin
            model_valid[i] = 1'b0;
        end
        model_gpio = '0;
        last_done  = 0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // request right after reset falls stalls through the hold
        do_transfer(0, 16'h0000, 1'b0, 16'h0000, rdata, n);
        check_equal(32'(n > RESET_HOLD_CYCLES), 32'h1, "pready inside soft reset hold");
        check_equal(32'(rdata), 32'h0, "gpio read after reset");

        // uncontested latency, edges counted from the request
        do_transfer(0, 16'h0010, 1'b1, 16'h5aa5, rdata, n);
        model_gpio = 16'h5aa5;
        check_equal(32'(n), 32'd3, "gpio transfer latency");
        check_equal(32'(gpio), 32'(model_gpio), "gpio pins after write");
        do_transfer(0, 16'h1000, 1'b1, 16'hc0de, rdata, n);
        model_ram[0]   = 16'hc0de;
        model_valid[0] = 1'b1;
        check_equal(32'(n), 32'd4, "ram transfer latency");

        fork
            begin
                for (int i = 0; i < NUM_TRANSFERS; i++) begin
                    random_transfer(0);
                end
            end
            begin
                for (int i = 0; i < NUM_TRANSFERS; i++) begin
                    random_transfer(1);
                end
            end
        join

        contend_once();
        // first winner finishes last, so the next tie goes the other way
        do_transfer(1 - last_done, 16'hf000, 1'b0, 16'h0000, rdata, n);
        contend_once();

        check_equal(32'(gpio), 32'(model_gpio), "gpio pins at end");
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/apb_pkg.sv
hw/soc_map_pkg.sv
hw/apb_if.sv
hw/reset_hold.sv
hw/apb_arbiter.sv
hw/apb_decoder.sv
hw/gpio_apb.sv
hw/bram_apb.sv
hw/apb_soc.sv
tests/tb_clock.sv
tests/apb_soc_asserts.sv
tests/apb_soc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the APB SoC testbench with Verilator and run it; exit status is the result
cd "$(dirname "$0")" \
    && verilator --binary --timing -f vlog.f --top-module apb_soc_tb -o apb_soc_sim \
    && ./obj_dir/apb_soc_sim \
    || { echo "APB SoC build or simulation did not pass"; exit 1; }
